/* files.f */
hw/pipe_pkg.sv
hw/exec_pkg.sv
hw/exec_lane.sv
hw/dcache_port.sv
hw/ex_mem_reg.sv
hw/execute_top.sv
tests/dcache_model.sv
tests/tb_execute.sv

/* hw/dcache_port.sv */
module dcache_port (
    input  logic                                       clk,
    input  logic                                       rst_i,
    input  logic                                       pause_i,
    input  logic [pipe_pkg::LANES-1:0]                 valid_i,
    input  logic [pipe_pkg::LANES-1:0]                 mem_need_i,
    input  logic [pipe_pkg::LANES-1:0]                 mispredict_i,
    input  exec_pkg::alu_op_e [pipe_pkg::LANES-1:0]    op_i,
    input  pipe_pkg::word_t [pipe_pkg::LANES-1:0]      mem_addr_i,
    input  pipe_pkg::word_t [pipe_pkg::LANES-1:0]      wdata_i,
    output logic                                       req_o,
    output logic                                       we_o,
    output pipe_pkg::word_t                            addr_o,
    output pipe_pkg::word_t                            wdata_o,
    input  logic                                       ack_i,
    input  pipe_pkg::word_t                            rdata_i,
    output logic [pipe_pkg::LANES-1:0]                 live_o,
    output pipe_pkg::word_t [pipe_pkg::LANES-1:0]      load_data_o,
    output logic                                       pause_ex_o
);
    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_REQ,
        PORT_RELEASE
    } port_state_e;

    port_state_e                                  state;
    logic [pipe_pkg::LANES-1:0]                   live;
    logic [pipe_pkg::LANES-1:0]                   done;
    logic [pipe_pkg::LANES-1:0]                   need;
    logic                                         start;
    logic                                         lane_sel;
    logic                                         lane_q;
    logic                                         we_q;
    pipe_pkg::word_t                              addr_q;
    pipe_pkg::word_t                              wdata_q;
    pipe_pkg::word_t [pipe_pkg::LANES-1:0]        load_q;

    // lane 1 dies behind a lane 0 mispredict
    assign live[0] = valid_i[0];
    assign live[1] = valid_i[1] && !mispredict_i[0];
    assign live_o  = live;

    assign need     = live & mem_need_i & ~done;
    assign lane_sel = !need[0];
    // new request only once the previous ack has dropped
    assign start    = (state == PORT_IDLE) && (|need) && !ack_i;

    assign pause_ex_o  = (|need) || (state != PORT_IDLE);
    assign req_o       = (state == PORT_REQ);
    assign we_o        = we_q;
    assign addr_o      = addr_q;
    assign wdata_o     = wdata_q;
    assign load_data_o = load_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state  <= PORT_IDLE;
            done   <= '0;
            lane_q <= 1'b0;
            we_q   <= 1'b0;
        end else begin
            case (state)
                PORT_IDLE: begin
                    if (start) begin
                        state  <= PORT_REQ;
                        lane_q <= lane_sel;
                        we_q   <= (op_i[lane_sel] == exec_pkg::OP_SW);
                    end
                end
                PORT_REQ: begin
                    if (ack_i) begin
                        state        <= PORT_RELEASE;
                        done[lane_q] <= 1'b1;
                    end
                end
                PORT_RELEASE: begin
                    if (!ack_i) begin
                        state <= PORT_IDLE;
                    end
                end
                default: state <= PORT_IDLE;
            endcase
            // bundle leaves the stage
            if (!pause_ex_o && !pause_i) begin
                done <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= mem_addr_i[lane_sel];
            wdata_q <= wdata_i[lane_sel];
        end
        // rdata valid on the ack edge
        if ((state == PORT_REQ) && ack_i && !we_q) begin
            load_q[lane_q] <= rdata_i;
        end
    end

    a_req_until_ack: assert property (@(posedge clk) disable iff (rst_i)
        req_o && !ack_i |=> req_o);

    a_addr_stable: assert property (@(posedge clk) disable iff (rst_i)
        req_o && !ack_i |=> $stable(addr_o));

endmodule

/* hw/ex_mem_reg.sv */
module ex_mem_reg (
    input  logic                                       clk,
    input  logic                                       rst_i,
    input  logic                                       flush_i,
    input  logic                                       pause_i,
    input  logic                                       pause_mem_i,
    input  logic                                       pause_ex_i,
    input  logic [pipe_pkg::LANES-1:0]                 live_i,
    input  logic [pipe_pkg::LANES-1:0]                 excp_i,
    input  logic [pipe_pkg::LANES-1:0]                 mispredict_i,
    input  logic [pipe_pkg::LANES-1:0]                 rd_we_i,
    input  exec_pkg::alu_op_e [pipe_pkg::LANES-1:0]    op_i,
    input  pipe_pkg::word_t [pipe_pkg::LANES-1:0]      pc_i,
    input  pipe_pkg::word_t [pipe_pkg::LANES-1:0]      result_i,
    input  pipe_pkg::word_t [pipe_pkg::LANES-1:0]      load_data_i,
    input  pipe_pkg::word_t [pipe_pkg::LANES-1:0]      redirect_i,
    input  pipe_pkg::reg_addr_t [pipe_pkg::LANES-1:0]  rd_addr_i,
    output logic [pipe_pkg::LANES-1:0]                 mem_valid_o,
    output logic [pipe_pkg::LANES-1:0]                 mem_we_o,
    output logic [pipe_pkg::LANES-1:0]                 mem_excp_o,
    output pipe_pkg::word_t [pipe_pkg::LANES-1:0]      mem_pc_o,
    output pipe_pkg::word_t [pipe_pkg::LANES-1:0]      mem_wdata_o,
    output pipe_pkg::reg_addr_t [pipe_pkg::LANES-1:0]  mem_waddr_o,
    output logic                                       branch_flush_o,
    output logic                                       excp_flush_o,
    output pipe_pkg::word_t                            branch_target_o
);
    logic [pipe_pkg::LANES-1:0] br_hit;
    logic [pipe_pkg::LANES-1:0] excp_hit;
    logic                       out_free;
    logic                       advance;

    assign advance = !pause_i && !pause_ex_i;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            mem_valid_o <= '0;
            mem_we_o    <= '0;
            mem_excp_o  <= '0;
        end else if (!pause_i) begin
            if (pause_ex_i) begin
                // bubble while the cache port is busy unless mem is stuck too
                if (!pause_mem_i) begin
                    mem_valid_o <= '0;
                    mem_we_o    <= '0;
                    mem_excp_o  <= '0;
                end
            end else begin
                mem_valid_o <= live_i;
                mem_we_o    <= live_i & rd_we_i & ~excp_i;
                mem_excp_o  <= live_i & excp_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < pipe_pkg::LANES; i++) begin
                mem_pc_o[i]    <= pc_i[i];
                mem_waddr_o[i] <= rd_addr_i[i];
                if (op_i[i] == exec_pkg::OP_LW) begin
                    mem_wdata_o[i] <= load_data_i[i];
                end else begin
                    mem_wdata_o[i] <= result_i[i];
                end
            end
        end
    end

    assign br_hit   = live_i & mispredict_i;
    assign excp_hit = live_i & excp_i;

    // no redirect while either stage is stalled
    assign out_free = !pause_ex_i && !pause_mem_i;

    assign branch_flush_o  = (|br_hit) && out_free;
    // older lane wins
    assign branch_target_o = br_hit[0] ? redirect_i[0] : redirect_i[1];
    assign excp_flush_o    = (|excp_hit) && out_free;

    a_no_flush_in_stall: assert property (@(posedge clk) disable iff (rst_i)
        !(branch_flush_o && pause_ex_i));

endmodule

/* hw/exec_lane.sv */
module exec_lane (
    input  logic              valid_i,
    input  pipe_pkg::word_t   pc_i,
    input  exec_pkg::alu_op_e op_i,
    input  pipe_pkg::word_t   src_a_i,
    input  pipe_pkg::word_t   src_b_i,
    input  pipe_pkg::word_t   imm_i,
    input  logic              pred_taken_i,
    input  pipe_pkg::word_t   pred_target_i,
    output pipe_pkg::word_t   result_o,
    output pipe_pkg::word_t   mem_addr_o,
    output logic              mem_need_o,
    output logic              excp_o,
    output logic              mispredict_o,
    output pipe_pkg::word_t   redirect_o
);
    logic            lt_signed;
    logic            taken;
    logic            is_mem;
    logic            is_branch;
    logic            misaligned;
    pipe_pkg::word_t taken_target;
    pipe_pkg::word_t seq_pc;

    assign lt_signed = $signed(src_a_i) < $signed(src_b_i);

    always_comb begin
        case (op_i)
            exec_pkg::OP_ADD: result_o = src_a_i + src_b_i;
            exec_pkg::OP_SUB: result_o = src_a_i - src_b_i;
            exec_pkg::OP_AND: result_o = src_a_i & src_b_i;
            exec_pkg::OP_OR:  result_o = src_a_i | src_b_i;
            exec_pkg::OP_XOR: result_o = src_a_i ^ src_b_i;
            exec_pkg::OP_SLT: result_o = {{(pipe_pkg::XLEN - 1){1'b0}}, lt_signed};
            // shift amount from the low five bits
            exec_pkg::OP_SLL: result_o = src_a_i << src_b_i[4:0];
            exec_pkg::OP_SRL: result_o = src_a_i >> src_b_i[4:0];
            default:          result_o = '0;
        endcase
    end

    // branch condition
    always_comb begin
        case (op_i)
            exec_pkg::OP_BEQ: taken = (src_a_i == src_b_i);
            exec_pkg::OP_BNE: taken = (src_a_i != src_b_i);
            exec_pkg::OP_BLT: taken = lt_signed;
            default:          taken = 1'b0;
        endcase
    end

    assign is_branch    = exec_pkg::is_branch_op(op_i);
    assign taken_target = pc_i + imm_i;
    assign seq_pc       = pc_i + pipe_pkg::word_t'(4);
    assign redirect_o   = taken ? taken_target : seq_pc;

    // wrong direction, or right direction with a stale target
    assign mispredict_o = valid_i && is_branch &&
                          ((taken != pred_taken_i) ||
                           (taken && (pred_target_i != taken_target)));

    // word address, must be 4-byte aligned
    assign mem_addr_o = src_a_i + imm_i;
    assign misaligned = (mem_addr_o[1:0] != 2'b00);
    assign is_mem     = exec_pkg::is_mem_op(op_i);
    assign mem_need_o = valid_i && is_mem && !misaligned;

    assign excp_o = valid_i && ((op_i == exec_pkg::OP_ERTN) || (is_mem && misaligned));

endmodule

/* hw/exec_pkg.sv */
package exec_pkg;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_ERTN
    } alu_op_e;

    // word loads and stores go through the cache port
    function automatic logic is_mem_op(alu_op_e op);
        return (op == OP_LW) || (op == OP_SW);
    endfunction

    function automatic logic is_branch_op(alu_op_e op);
        return (op == OP_BEQ) || (op == OP_BNE) || (op == OP_BLT);
    endfunction

endpackage

/* hw/execute_top.sv */
module execute_top (
    input  logic                                       clk,
    input  logic                                       rst_i,
    input  logic [pipe_pkg::LANES-1:0]                 valid_i,
    input  pipe_pkg::word_t [pipe_pkg::LANES-1:0]      pc_i,
    input  exec_pkg::alu_op_e [pipe_pkg::LANES-1:0]    op_i,
    input  pipe_pkg::word_t [pipe_pkg::LANES-1:0]      src_a_i,
    input  pipe_pkg::word_t [pipe_pkg::LANES-1:0]      src_b_i,
    input  pipe_pkg::word_t [pipe_pkg::LANES-1:0]      imm_i,
    input  logic [pipe_pkg::LANES-1:0]                 rd_we_i,
    input  pipe_pkg::reg_addr_t [pipe_pkg::LANES-1:0]  rd_addr_i,
    input  logic [pipe_pkg::LANES-1:0]                 pred_taken_i,
    input  pipe_pkg::word_t [pipe_pkg::LANES-1:0]      pred_target_i,
    input  logic                                       flush_i,
    input  logic                                       pause_i,
    input  logic                                       pause_mem_i,
    output logic                                       req_o,
    output logic                                       we_o,
    output pipe_pkg::word_t                            addr_o,
    output pipe_pkg::word_t                            wdata_o,
    input  logic                                       ack_i,
    input  pipe_pkg::word_t                            rdata_i,
    output logic                                       pause_ex_o,
    output logic                                       branch_flush_o,
    output pipe_pkg::word_t                            branch_target_o,
    output logic                                       excp_flush_o,
    output logic [pipe_pkg::LANES-1:0]                 mem_valid_o,
    output logic [pipe_pkg::LANES-1:0]                 mem_we_o,
    output logic [pipe_pkg::LANES-1:0]                 mem_excp_o,
    output pipe_pkg::word_t [pipe_pkg::LANES-1:0]      mem_pc_o,
    output pipe_pkg::word_t [pipe_pkg::LANES-1:0]      mem_wdata_o,
    output pipe_pkg::reg_addr_t [pipe_pkg::LANES-1:0]  mem_waddr_o
);
    pipe_pkg::word_t [pipe_pkg::LANES-1:0] lane_result;
    pipe_pkg::word_t [pipe_pkg::LANES-1:0] lane_mem_addr;
    pipe_pkg::word_t [pipe_pkg::LANES-1:0] lane_redirect;
    pipe_pkg::word_t [pipe_pkg::LANES-1:0] load_data;
    logic [pipe_pkg::LANES-1:0]            lane_mem_need;
    logic [pipe_pkg::LANES-1:0]            lane_excp;
    logic [pipe_pkg::LANES-1:0]            lane_mispredict;
    logic [pipe_pkg::LANES-1:0]            live;

    exec_lane u_lane_0 (
        .valid_i       (valid_i[0]),
        .pc_i          (pc_i[0]),
        .op_i          (op_i[0]),
        .src_a_i       (src_a_i[0]),
        .src_b_i       (src_b_i[0]),
        .imm_i         (imm_i[0]),
        .pred_taken_i  (pred_taken_i[0]),
        .pred_target_i (pred_target_i[0]),
        .result_o      (lane_result[0]),
        .mem_addr_o    (lane_mem_addr[0]),
        .mem_need_o    (lane_mem_need[0]),
        .excp_o        (lane_excp[0]),
        .mispredict_o  (lane_mispredict[0]),
        .redirect_o    (lane_redirect[0])
    );

    exec_lane u_lane_1 (
        .valid_i       (valid_i[1]),
        .pc_i          (pc_i[1]),
        .op_i          (op_i[1]),
        .src_a_i       (src_a_i[1]),
        .src_b_i       (src_b_i[1]),
        .imm_i         (imm_i[1]),
        .pred_taken_i  (pred_taken_i[1]),
        .pred_target_i (pred_target_i[1]),
        .result_o      (lane_result[1]),
        .mem_addr_o    (lane_mem_addr[1]),
        .mem_need_o    (lane_mem_need[1]),
        .excp_o        (lane_excp[1]),
        .mispredict_o  (lane_mispredict[1]),
        .redirect_o    (lane_redirect[1])
    );

    // store data is the second source operand
    dcache_port u_dcache_port (
        .clk          (clk),
        .rst_i        (rst_i),
        .pause_i      (pause_i),
        .valid_i      (valid_i),
        .mem_need_i   (lane_mem_need),
        .mispredict_i (lane_mispredict),
        .op_i         (op_i),
        .mem_addr_i   (lane_mem_addr),
        .wdata_i      (src_b_i),
        .req_o        (req_o),
        .we_o         (we_o),
        .addr_o       (addr_o),
        .wdata_o      (wdata_o),
        .ack_i        (ack_i),
        .rdata_i      (rdata_i),
        .live_o       (live),
        .load_data_o  (load_data),
        .pause_ex_o   (pause_ex_o)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk             (clk),
        .rst_i           (rst_i),
        .flush_i         (flush_i),
        .pause_i         (pause_i),
        .pause_mem_i     (pause_mem_i),
        .pause_ex_i      (pause_ex_o),
        .live_i          (live),
        .excp_i          (lane_excp),
        .mispredict_i    (lane_mispredict),
        .rd_we_i         (rd_we_i),
        .op_i            (op_i),
        .pc_i            (pc_i),
        .result_i        (lane_result),
        .load_data_i     (load_data),
        .redirect_i      (lane_redirect),
        .rd_addr_i       (rd_addr_i),
        .mem_valid_o     (mem_valid_o),
        .mem_we_o        (mem_we_o),
        .mem_excp_o      (mem_excp_o),
        .mem_pc_o        (mem_pc_o),
        .mem_wdata_o     (mem_wdata_o),
        .mem_waddr_o     (mem_waddr_o),
        .branch_flush_o  (branch_flush_o),
        .excp_flush_o    (excp_flush_o),
        .branch_target_o (branch_target_o)
    );

endmodule

/* hw/pipe_pkg.sv */
package pipe_pkg;

    // datapath width, ISA fixed
    localparam int XLEN = 32;

    // issue lanes per bundle
    localparam int LANES = 2;

    typedef logic [XLEN-1:0] word_t;

    // architectural register number
    typedef logic [4:0] reg_addr_t;

endpackage

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tb_execute -o sim_tb_execute
./obj_dir/sim_tb_execute

/* tests/dcache_model.sv */
module dcache_model (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            req_i,
    input  logic            we_i,
    input  pipe_pkg::word_t addr_i,
    input  pipe_pkg::word_t wdata_i,
    output logic            ack_o,
    output pipe_pkg::word_t rdata_o
);
    pipe_pkg::word_t mem [0:255];
    integer          seed;
    logic [31:0]     r;

    initial begin
        seed = 32'hec5d;
        ack_o <= 1'b0;
        rdata_o <= '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        end
        forever begin
            @(posedge clk);
            if (!rst_i && req_i) begin
                r = $random(seed);
                repeat (r[1:0]) @(posedge clk);
                // rdata goes up together with ack
                ack_o <= 1'b1;
                if (we_i) begin
                    mem[addr_i[9:2]] <= wdata_i;
                end else begin
                    rdata_o <= mem[addr_i[9:2]];
                end
                do begin
                    @(posedge clk);
                end while (req_i);
                r = $random(seed);
                repeat (r[1:0]) @(posedge clk);
                ack_o <= 1'b0;
            end
        end
    end

endmodule

/* tests/tb_execute.sv */
module tb_execute;
    localparam int NUM_BUNDLES = 200;
    localparam int CYCLE_LIMIT = NUM_BUNDLES * 20 + 100;

    typedef struct packed {
        logic [1:0]                 valid;
        logic [1:0]                 we;
        logic [1:0]                 excp;
        pipe_pkg::word_t [1:0]      pc;
        pipe_pkg::word_t [1:0]      wdata;
        pipe_pkg::reg_addr_t [1:0]  waddr;
    } exp_t;

    typedef struct packed {
        logic            we;
        pipe_pkg::word_t addr;
        pipe_pkg::word_t wdata;
    } req_t;

    logic clk;
    logic rst_i;
    logic flush_i;
    logic pause_i;
    logic pause_mem_i;
    logic [1:0] valid_i;
    logic [1:0] rd_we_i;
    logic [1:0] pred_taken_i;
    pipe_pkg::word_t [1:0] pc_i;
    pipe_pkg::word_t [1:0] src_a_i;
    pipe_pkg::word_t [1:0] src_b_i;
    pipe_pkg::word_t [1:0] imm_i;
    pipe_pkg::word_t [1:0] pred_target_i;
    pipe_pkg::reg_addr_t [1:0] rd_addr_i;
    exec_pkg::alu_op_e [1:0] op_i;
    logic req_o;
    logic we_o;
    logic ack_i;
    pipe_pkg::word_t addr_o;
    pipe_pkg::word_t wdata_o;
    pipe_pkg::word_t rdata_i;
    logic pause_ex_o;
    logic branch_flush_o;
    logic excp_flush_o;
    pipe_pkg::word_t branch_target_o;
    logic [1:0] mem_valid_o;
    logic [1:0] mem_we_o;
    logic [1:0] mem_excp_o;
    pipe_pkg::word_t [1:0] mem_pc_o;
    pipe_pkg::word_t [1:0] mem_wdata_o;
    pipe_pkg::reg_addr_t [1:0] mem_waddr_o;

    integer seed;
    int cycles = 0;
    logic req_q = 1'b0;
    exp_t exp_q[$];
    req_t exp_req_q[$];
    pipe_pkg::word_t mirror [0:255];

    execute_top u_dut (.*);

    dcache_model u_dcache_model (
        .clk     (clk),
        .rst_i   (rst_i),
        .req_i   (req_o),
        .we_i    (we_o),
        .addr_i  (addr_o),
        .wdata_i (wdata_o),
        .ack_o   (ack_i),
        .rdata_o (rdata_i)
    );

    always #4 clk = ~clk;

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // expected outcome of one lane
    // memory ops go to the mirror and the request queue in issue order
    function automatic void ref_lane(input logic live, input exec_pkg::alu_op_e op,
                                     input pipe_pkg::word_t pc, a, b, imm,
                                     input logic pt, input pipe_pkg::word_t ptgt,
                                     output pipe_pkg::word_t res, output logic excp,
                                     output logic mis, output logic need,
                                     output pipe_pkg::word_t redir);
        logic taken;
        logic memop;
        logic branch;
        pipe_pkg::word_t addr;
        req_t rq;
        addr = a + imm;
        taken = 1'b0;
        res = '0;
        case (op)
            exec_pkg::OP_ADD: res = a + b;
            exec_pkg::OP_SUB: res = a - b;
            exec_pkg::OP_AND: res = a & b;
            exec_pkg::OP_OR:  res = a | b;
            exec_pkg::OP_XOR: res = a ^ b;
            exec_pkg::OP_SLT: res = {31'b0, $signed(a) < $signed(b)};
            exec_pkg::OP_SLL: res = a << b[4:0];
            exec_pkg::OP_SRL: res = a >> b[4:0];
            exec_pkg::OP_BEQ: taken = (a == b);
            exec_pkg::OP_BNE: taken = (a != b);
            exec_pkg::OP_BLT: taken = $signed(a) < $signed(b);
            default: ;
        endcase
        memop = (op == exec_pkg::OP_LW) || (op == exec_pkg::OP_SW);
        branch = (op == exec_pkg::OP_BEQ) || (op == exec_pkg::OP_BNE) || (op == exec_pkg::OP_BLT);
        excp = live && ((op == exec_pkg::OP_ERTN) || (memop && addr[1:0] != 2'b00));
        need = live && memop && (addr[1:0] == 2'b00);
        redir = taken ? pc + imm : pc + 4;
        mis = live && branch && ((taken != pt) || (taken && ptgt != pc + imm));
        if (need) begin
            rq.we = (op == exec_pkg::OP_SW);
            rq.addr = addr;
            rq.wdata = b;
            exp_req_q.push_back(rq);
        end
        if (need && op == exec_pkg::OP_LW) begin
            res = mirror[addr[9:2]];
        end else if (need) begin
            mirror[addr[9:2]] = b;
        end
    endfunction

    initial begin
        exp_t e;
        exp_t e_prev;
        logic have_prev;
        logic first;
        logic [31:0] r;
        logic [1:0] live;
        logic [1:0] lmis;
        logic [1:0] lexcp;
        logic [1:0] lneed;
        logic [1:0] g_valid;
        logic [1:0] g_we;
        logic [1:0] g_pt;
        pipe_pkg::word_t [1:0] g_pc;
        pipe_pkg::word_t [1:0] g_a;
        pipe_pkg::word_t [1:0] g_b;
        pipe_pkg::word_t [1:0] g_imm;
        pipe_pkg::word_t [1:0] g_tgt;
        pipe_pkg::word_t [1:0] res;
        pipe_pkg::word_t [1:0] redir;
        pipe_pkg::reg_addr_t [1:0] g_rd;
        exec_pkg::alu_op_e [1:0] g_op;

        seed = 32'hec5d;
        clk = 1'b0;
        rst_i <= 1'b1;
        flush_i <= 1'b0;
        pause_i <= 1'b0;
        pause_mem_i <= 1'b0;
        valid_i <= '0;
        rd_we_i <= '0;
        pred_taken_i <= '0;
        pc_i <= '0;
        src_a_i <= '0;
        src_b_i <= '0;
        imm_i <= '0;
        pred_target_i <= '0;
        rd_addr_i <= '0;
        op_i[0] <= exec_pkg::OP_NOP;
        op_i[1] <= exec_pkg::OP_NOP;
        for (int i = 0; i < 256; i++) begin
            mirror[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        end
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        have_prev = 1'b0;

        for (int n = 0; n < NUM_BUNDLES; n++) begin
            @(posedge clk);
            if (have_prev) begin
                exp_q.push_back(e_prev);
            end
            for (int l = 0; l < 2; l++) begin
                r = $random(seed);
                g_valid[l] = (r[2:0] != 3'b000);
                g_op[l] = exec_pkg::alu_op_e'(4'(r[31:8] % 15));
                g_pc[l] = $random(seed) & 32'hffff_fffc;
                g_a[l] = $random(seed);
                g_b[l] = $random(seed);
                g_imm[l] = $random(seed) & 32'hff;
                r = $random(seed);
                if (g_op[l] == exec_pkg::OP_LW || g_op[l] == exec_pkg::OP_SW) begin
                    // misaligned about one time in four
                    g_a[l][1:0] = 2'b00;
                    g_imm[l][1:0] = (r[3:2] == 2'b00) ? r[1:0] : 2'b00;
                end else if (g_op[l] >= exec_pkg::OP_BEQ && g_op[l] <= exec_pkg::OP_BLT) begin
                    g_a[l] = {{30{r[4]}}, r[1:0]};
                    g_b[l] = {{30{r[5]}}, r[3:2]};
                end
                g_pt[l] = r[6];
                g_tgt[l] = r[7] ? g_pc[l] + g_imm[l] : g_pc[l] + 8;
                g_rd[l] = r[12:8];
                g_we[l] = (g_op[l] >= exec_pkg::OP_ADD && g_op[l] <= exec_pkg::OP_SRL) ||
                          (g_op[l] == exec_pkg::OP_LW);
            end
            live[0] = g_valid[0];
            ref_lane(live[0], g_op[0], g_pc[0], g_a[0], g_b[0], g_imm[0], g_pt[0], g_tgt[0],
                     res[0], lexcp[0], lmis[0], lneed[0], redir[0]);
            live[1] = g_valid[1] && !lmis[0];
            ref_lane(live[1], g_op[1], g_pc[1], g_a[1], g_b[1], g_imm[1], g_pt[1], g_tgt[1],
                     res[1], lexcp[1], lmis[1], lneed[1], redir[1]);
            valid_i <= g_valid;
            op_i <= g_op;
            pc_i <= g_pc;
            src_a_i <= g_a;
            src_b_i <= g_b;
            imm_i <= g_imm;
            pred_taken_i <= g_pt;
            pred_target_i <= g_tgt;
            rd_we_i <= g_we;
            rd_addr_i <= g_rd;
            e.valid = live;
            e.we = live & g_we & ~lexcp;
            e.excp = live & lexcp;
            e.pc = g_pc;
            e.wdata = res;
            e.waddr = g_rd;

            first = 1'b1;
            do begin
                @(negedge clk);
                if (first) begin
                    check_equal(32'(pause_ex_o), 32'(|lneed), "pause_ex_o at presentation");
                end
                first = 1'b0;
            end while (pause_ex_o);
            check_equal(32'(branch_flush_o), 32'(|lmis), "branch_flush_o");
            if (|lmis) begin
                check_equal(branch_target_o, lmis[0] ? redir[0] : redir[1], "branch_target_o");
            end
            check_equal(32'(excp_flush_o), 32'(|lexcp), "excp_flush_o");
            e_prev = e;
            have_prev = 1'b1;
        end
        @(posedge clk);
        exp_q.push_back(e_prev);
        valid_i <= '0;

        // hold under pause_i and then flush
        @(posedge clk);
        valid_i <= 2'b11;
        op_i[0] <= exec_pkg::OP_ADD;
        op_i[1] <= exec_pkg::OP_ADD;
        ref_lane(1'b1, exec_pkg::OP_ADD, g_pc[0], g_a[0], g_b[0], g_imm[0], 1'b0, g_tgt[0],
                 res[0], lexcp[0], lmis[0], lneed[0], redir[0]);
        e.wdata[0] = res[0];
        e.pc[1] = g_pc[1];
        @(posedge clk);
        pause_i <= 1'b1;
        src_a_i[0] <= src_a_i[0] + 1;
        pc_i[1] <= pc_i[1] + 4;
        @(negedge clk);
        check_equal(32'(mem_valid_o), 32'd3, "mem_valid_o before pause");
        repeat (3) begin
            @(negedge clk);
            check_equal(32'(mem_valid_o), 32'd3, "mem_valid_o held by pause_i");
            check_equal(mem_wdata_o[0], e.wdata[0], "mem_wdata_o[0] held by pause_i");
            check_equal(mem_pc_o[1], e.pc[1], "mem_pc_o[1] held by pause_i");
        end
        @(posedge clk);
        flush_i <= 1'b1;
        pause_i <= 1'b0;
        @(posedge clk);
        flush_i <= 1'b0;
        valid_i <= '0;
        @(negedge clk);
        check_equal(32'(mem_valid_o), 32'd0, "mem_valid_o after flush_i");
        check_equal(32'(exp_req_q.size()), 32'd0, "cache requests never issued");
        $display("Simulation finished: PASS");
        $finish;
    end

    always @(negedge clk) begin : compare_mem
        exp_t e;
        req_t rq;
        // a new request waits for ack low
        if (req_o && !req_q) begin
            check_equal(32'(ack_i), 32'd0, "req_o rose while ack_i high");
            check_equal(32'(exp_req_q.size() != 0), 32'd1, "cache request with none expected");
            rq = exp_req_q.pop_front();
            check_equal(32'(we_o), 32'(rq.we), "we_o");
            check_equal(addr_o, rq.addr, "addr_o");
            if (rq.we) begin
                check_equal(wdata_o, rq.wdata, "wdata_o");
            end
        end
        req_q = req_o;
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_equal(32'(mem_valid_o), 32'(e.valid), "mem_valid_o");
            check_equal(32'(mem_we_o), 32'(e.we), "mem_we_o");
            check_equal(32'(mem_excp_o), 32'(e.excp), "mem_excp_o");
            for (int l = 0; l < 2; l++) begin
                if (e.valid[l]) begin
                    check_equal(mem_pc_o[l], e.pc[l], "mem_pc_o");
                end
                if (e.we[l]) begin
                    check_equal(mem_wdata_o[l], e.wdata[l], "mem_wdata_o");
                    check_equal(32'(mem_waddr_o[l]), 32'(e.waddr[l]), "mem_waddr_o");
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

endmodule
